/* verilog/masku_pkg.sv */
`default_nettype none

package masku_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int unsigned NrLanes      = 2;
  localparam int unsigned ELEN         = 64;
  localparam int unsigned ELENB        = ELEN / 8;
  localparam int unsigned DataWidth    = NrLanes * ELEN;
  localparam int unsigned NrMaskFUnits = 2;
  localparam int unsigned NrOpSlots    = NrMaskFUnits + 2;
  localparam int unsigned PntWidth     = 7;

  typedef logic [ELEN-1:0] elen_t;

  // Slot offset above the v0 and vd slots
  typedef enum logic [0:0] {
    ALU = 1'b0,
    FPU = 1'b1
  } masku_fu_e;

  // log2 of the element width in bytes
  typedef enum logic [1:0] {
    E8  = 2'd0,
    E16 = 2'd1,
    E32 = 2'd2,
    E64 = 2'd3
  } sew_e;

  typedef enum logic [1:0] {
    MCMP  = 2'd0,
    VMAND = 2'd1,
    VMOR  = 2'd2,
    VMXOR = 2'd3
  } mask_op_e;

  typedef struct packed {
    mask_op_e            op;
    masku_fu_e           fu;
    sew_e                sew;
    logic                vm;
    logic [PntWidth-1:0] vrf_pnt;
  } masku_insn_t;

  // One lane's operand words
  typedef struct packed {
    elen_t m;
    elen_t vd;
    elen_t alu;
    elen_t fpu;
  } lane_operands_t;

  // --------------------------------------------------------------------------
  // Byte layout across the lanes
  // --------------------------------------------------------------------------

  // Sequential byte index to shuffled byte index
  function automatic int unsigned shuffle_index(input int unsigned byte_idx, input sew_e sew);
    int unsigned elem;
    int unsigned lane;
    int unsigned pos;
    elem = byte_idx >> sew;
    lane = elem % NrLanes;
    pos  = ((elem / NrLanes) << sew) + (byte_idx % (1 << sew));
    return lane * ELENB + pos;
  endfunction

  // Shuffled byte index back to sequential byte index
  function automatic int unsigned deshuffle_index(input int unsigned byte_idx, input sew_e sew);
    int unsigned lane;
    int unsigned pos;
    int unsigned elem;
    lane = byte_idx / ELENB;
    pos  = byte_idx % ELENB;
    elem = (pos >> sew) * NrLanes + lane;
    return (elem << sew) + (pos % (1 << sew));
  endfunction

endpackage

`default_nettype wire

/* verilog/operand_spill.sv */
`default_nettype none

module operand_spill import masku_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                valid_i,
  output logic                     ready_o,
  input  wire elen_t [NrLanes-1:0] data_i,
  output logic                     valid_o,
  input  wire logic                ready_i,
  output elen_t [NrLanes-1:0]      data_o
);

  elen_t [1:0][NrLanes-1:0] mem_q;
  logic [1:0]               count_q;
  logic                     wr_ptr_q;
  logic                     rd_ptr_q;
  logic                     push;
  logic                     pop;

  // Handshake depends on fill level only
  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q  <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      if (push && !pop) count_q <= count_q + 2'd1;
      else if (pop && !push) count_q <= count_q - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

/* verilog/masku_operands.sv */
`default_nettype none

module masku_operands import masku_pkg::*; (
  input  wire logic                                     clk_i,
  input  wire logic                                     reset_i,
  input  wire masku_insn_t                              insn_i,
  input  wire lane_operands_t [NrLanes-1:0]             lane_operands_i,
  input  wire logic           [NrLanes-1:0][NrOpSlots-1:0] lane_valid_i,
  output logic                [NrLanes-1:0][NrOpSlots-1:0] lane_ready_o,
  output logic [DataWidth-1:0]                          alu_seq_o,
  output logic [DataWidth-1:0]                          vd_seq_o,
  output logic [DataWidth-1:0]                          m_seq_o,
  output logic [DataWidth-1:0]                          compressed_o,
  output logic [DataWidth-1:0]                          bit_enable_o,
  output logic                                          ops_valid_o,
  input  wire logic                                     ops_consume_i
);

  elen_t [NrLanes-1:0] vd_d, m_d, vd_q, m_q, alu_shuf;
  logic vd_lane_valid, vd_lane_ready, vd_spill_valid;
  logic m_lane_valid, m_lane_ready, m_spill_valid;
  logic alu_valid;

  // --------------------------------------------------------------------------
  // Gather lane words and joint valids
  // --------------------------------------------------------------------------
  always_comb begin
    vd_lane_valid = 1'b1;
    m_lane_valid  = 1'b1;
    alu_valid     = 1'b1;
    for (int l = 0; l < NrLanes; l++) begin
      m_d[l]      = lane_operands_i[l].m;
      vd_d[l]     = lane_operands_i[l].vd;
      alu_shuf[l] = (insn_i.fu == FPU) ? lane_operands_i[l].fpu : lane_operands_i[l].alu;
      m_lane_valid  &= lane_valid_i[l][0];
      vd_lane_valid &= lane_valid_i[l][1];
      alu_valid     &= lane_valid_i[l][2 + int'(insn_i.fu)];
    end
  end

  operand_spill i_spill_vd (
    .clk_i, .reset_i,
    .valid_i (vd_lane_valid), .ready_o (vd_lane_ready), .data_i (vd_d),
    .valid_o (vd_spill_valid), .ready_i (ops_consume_i), .data_o (vd_q)
  );

  operand_spill i_spill_m (
    .clk_i, .reset_i,
    .valid_i (m_lane_valid), .ready_o (m_lane_ready), .data_i (m_d),
    .valid_o (m_spill_valid), .ready_i (ops_consume_i), .data_o (m_q)
  );

  assign ops_valid_o = vd_spill_valid && m_spill_valid && alu_valid;

  // Lanes only see a transfer when every lane moves together
  always_comb begin
    lane_ready_o = '0;
    for (int l = 0; l < NrLanes; l++) begin
      lane_ready_o[l][0] = m_lane_ready && m_lane_valid;
      lane_ready_o[l][1] = vd_lane_ready && vd_lane_valid;
      for (int f = 0; f < NrMaskFUnits; f++) begin
        lane_ready_o[l][2+f] = (insn_i.fu == masku_fu_e'(f)) && ops_consume_i;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Deshuffle into sequential order
  // --------------------------------------------------------------------------
  always_comb begin
    alu_seq_o = '0;
    vd_seq_o  = '0;
    m_seq_o   = '0;
    for (int unsigned b = 0; b < NrLanes * ELENB; b++) begin
      alu_seq_o[8*deshuffle_index(b, insn_i.sew) +: 8] = alu_shuf[b/ELENB][8*(b%ELENB) +: 8];
      vd_seq_o[8*deshuffle_index(b, E8) +: 8]          = vd_q[b/ELENB][8*(b%ELENB) +: 8];
      m_seq_o[8*deshuffle_index(b, E8) +: 8]           = m_q[b/ELENB][8*(b%ELENB) +: 8];
    end
  end

  // --------------------------------------------------------------------------
  // Compression and bit enable
  // --------------------------------------------------------------------------
  always_comb begin
    int unsigned nelem;
    int unsigned dst;
    nelem        = (DataWidth / 8) >> insn_i.sew;
    compressed_o = '0;
    bit_enable_o = (insn_i.op == MCMP) ? '0 : '1;
    for (int unsigned e = 0; e < DataWidth / 8; e++) begin
      dst = int'(insn_i.vrf_pnt) + e;
      if (e < nelem && dst < DataWidth) begin
        // LSB of each sequential element
        compressed_o[dst] = alu_seq_o[8 * (e << insn_i.sew)];
        if (insn_i.op == MCMP) bit_enable_o[dst] = insn_i.vm || m_seq_o[dst];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/masku_alu.sv */
`default_nettype none

module masku_alu import masku_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire masku_insn_t          insn_i,
  input  wire logic [DataWidth-1:0] alu_seq_i,
  input  wire logic [DataWidth-1:0] vd_seq_i,
  input  wire logic [DataWidth-1:0] m_seq_i,
  input  wire logic [DataWidth-1:0] compressed_i,
  input  wire logic [DataWidth-1:0] bit_enable_i,
  input  wire logic                 ops_valid_i,
  output logic                      ops_consume_o,
  output logic [DataWidth-1:0]      result_o,
  output logic                      result_valid_o,
  input  wire logic                 result_ready_i
);

  logic [DataWidth-1:0] new_bits;
  logic [DataWidth-1:0] result_seq;
  logic [DataWidth-1:0] result_shuf;
  logic [DataWidth-1:0] result_q;
  logic                 result_valid_q;

  // Output register empty or draining this cycle
  assign ops_consume_o = ops_valid_i && (!result_valid_q || result_ready_i);

  // --------------------------------------------------------------------------
  // Result computation
  // --------------------------------------------------------------------------
  always_comb begin
    unique case (insn_i.op)
      VMAND:   new_bits = alu_seq_i & m_seq_i;
      VMOR:    new_bits = alu_seq_i | m_seq_i;
      VMXOR:   new_bits = alu_seq_i ^ m_seq_i;
      default: new_bits = compressed_i;
    endcase
  end

  // Tail and masked-off bits keep vd
  assign result_seq = (new_bits & bit_enable_i) | (vd_seq_i & ~bit_enable_i);

  // Back to lane layout, byte granular
  always_comb begin
    result_shuf = '0;
    for (int unsigned b = 0; b < DataWidth / 8; b++) begin
      result_shuf[8*shuffle_index(b, E8) +: 8] = result_seq[8*b +: 8];
    end
  end

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_valid_q <= 1'b0;
    end else if (ops_consume_o) begin
      result_valid_q <= 1'b1;
    end else if (result_ready_i) begin
      result_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ops_consume_o) result_q <= result_shuf;
  end

  assign result_o       = result_q;
  assign result_valid_o = result_valid_q;

endmodule

`default_nettype wire

/* verilog/masku_top.sv */
`default_nettype none

module masku_top import masku_pkg::*; (
  input  wire logic                                        clk_i,
  input  wire logic                                        reset_i,
  input  wire masku_insn_t                                 insn_i,
  input  wire lane_operands_t [NrLanes-1:0]                lane_operands_i,
  input  wire logic           [NrLanes-1:0][NrOpSlots-1:0] lane_valid_i,
  output logic                [NrLanes-1:0][NrOpSlots-1:0] lane_ready_o,
  output logic [DataWidth-1:0]                             result_o,
  output logic                                             result_valid_o,
  input  wire logic                                        result_ready_i
);

  // Sequential operands between the stages
  logic [DataWidth-1:0] alu_seq, vd_seq, m_seq, compressed, bit_enable;
  logic                 ops_valid;
  logic                 ops_consume;

  masku_operands i_operands (
    .clk_i, .reset_i, .insn_i,
    .lane_operands_i, .lane_valid_i, .lane_ready_o,
    .alu_seq_o     (alu_seq),
    .vd_seq_o      (vd_seq),
    .m_seq_o       (m_seq),
    .compressed_o  (compressed),
    .bit_enable_o  (bit_enable),
    .ops_valid_o   (ops_valid),
    .ops_consume_i (ops_consume)
  );

  masku_alu i_alu (
    .clk_i, .reset_i, .insn_i,
    .alu_seq_i     (alu_seq),
    .vd_seq_i      (vd_seq),
    .m_seq_i       (m_seq),
    .compressed_i  (compressed),
    .bit_enable_i  (bit_enable),
    .ops_valid_i   (ops_valid),
    .ops_consume_o (ops_consume),
    .result_o, .result_valid_o, .result_ready_i
  );

endmodule

`default_nettype wire

/* dv/masku_asserts.sv */
`default_nettype none

module masku_asserts import masku_pkg::*; (
  input wire logic                              clk_i,
  input wire logic                              reset_i,
  input wire masku_insn_t                       insn_i,
  input wire logic [NrLanes-1:0][NrOpSlots-1:0] lane_ready_o,
  input wire logic [DataWidth-1:0]              result_o,
  input wire logic                              result_valid_o,
  input wire logic                              result_ready_i
);

  int unsigned assert_fails = 0;
  logic        unsel_ready;

  // Ready seen on any lane for the FU slot not picked by insn_i.fu
  always_comb begin
    unsel_ready = 1'b0;
    for (int l = 0; l < NrLanes; l++) begin
      for (int f = 0; f < NrMaskFUnits; f++) begin
        if (f != int'(insn_i.fu)) unsel_ready = unsel_ready | lane_ready_o[l][2+f];
      end
    end
  end

  reset_clears_valid: assert property (@(posedge clk_i) reset_i |=> !result_valid_o)
    else begin
      assert_fails++;
      $error("result_valid_o is high in the cycle after reset");
    end

  // Output register frozen under back-pressure
  hold_while_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
    else begin
      assert_fails++;
      $error("result changed or dropped while the consumer stalled");
    end

  unselected_fu_idle: assert property (@(posedge clk_i) disable iff (reset_i) !unsel_ready)
    else begin
      assert_fails++;
      $error("lane_ready_o raised for the unselected FU slot");
    end

endmodule

`default_nettype wire

/* dv/tb_masku.sv */
`default_nettype none

module tb_masku import masku_pkg::*; ();

  localparam int unsigned ShortBeats     = 8;
  localparam int unsigned TotalBeats     = 6 * ShortBeats + 200;
  localparam int unsigned WatchdogCycles = TotalBeats * 40 + 100;

  logic                              clk_i;
  logic                              reset_i;
  masku_insn_t                       insn_i;
  lane_operands_t [NrLanes-1:0]      lane_operands_i;
  logic [NrLanes-1:0][NrOpSlots-1:0] lane_valid_i;
  logic [NrLanes-1:0][NrOpSlots-1:0] lane_ready_o;
  logic [DataWidth-1:0]              result_o;
  logic                              result_valid_o;
  logic                              result_ready_i;

  // Per beat words in lane layout; streams 0, 1, 2 are v0, vd and the FU slot
  logic [DataWidth-1:0] beat_m [$];
  logic [DataWidth-1:0] beat_vd [$];
  logic [DataWidth-1:0] beat_fu [$];
  int unsigned          idx [3];
  logic [NrLanes-1:0]   lane_vld [3];
  logic                 fire [3];
  int unsigned          n_beats;
  logic                 random_mode;
  logic [31:0]          lcg_state;

  // Words seen on the lane side and expected results in order
  logic [DataWidth-1:0] got_m [$];
  logic [DataWidth-1:0] got_vd [$];
  logic [DataWidth-1:0] exp_q [$];
  int unsigned          rcv_count;
  int unsigned          check_count;
  int unsigned          err_count;
  string                cur_test;

  masku_top DUT (
    .clk_i, .reset_i, .insn_i,
    .lane_operands_i, .lane_valid_i, .lane_ready_o,
    .result_o, .result_valid_o, .result_ready_i
  );

  bind masku_top masku_asserts i_asserts (
    .clk_i, .reset_i, .insn_i, .lane_ready_o,
    .result_o, .result_valid_o, .result_ready_i
  );

  // ---------------------------------------------------------------------------
  // Random numbers and reference model
  // ---------------------------------------------------------------------------
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic logic [DataWidth-1:0] rand_word();
    logic [DataWidth-1:0] w;
    for (int i = 0; i < DataWidth / 16; i++) w[16*i +: 16] = lcg_next();
    return w;
  endfunction

  // Lane layout byte holding sequential byte b at element width 2**sew bytes
  function automatic int unsigned lane_byte_of(input int unsigned b, input int unsigned sew);
    int unsigned elem;
    elem = b >> sew;
    return (elem % NrLanes) * ELENB + ((elem / NrLanes) << sew) + (b % (1 << sew));
  endfunction

  function automatic logic [DataWidth-1:0] to_sequential(input logic [DataWidth-1:0] w,
                                                         input int unsigned sew);
    logic [DataWidth-1:0] s;
    for (int unsigned b = 0; b < DataWidth / 8; b++) s[8*b +: 8] = w[8*lane_byte_of(b, sew) +: 8];
    return s;
  endfunction

  function automatic logic [DataWidth-1:0] to_lanes(input logic [DataWidth-1:0] s);
    logic [DataWidth-1:0] w;
    for (int unsigned b = 0; b < DataWidth / 8; b++) w[8*lane_byte_of(b, 0) +: 8] = s[8*b +: 8];
    return w;
  endfunction

  function automatic logic [DataWidth-1:0] expected_result(input masku_insn_t insn,
      input logic [DataWidth-1:0] fu_w, input logic [DataWidth-1:0] vd_w,
      input logic [DataWidth-1:0] m_w);
    logic [DataWidth-1:0] src, vd_s, m_s, res;
    int unsigned sew, nelem, dst;
    sew  = int'(insn.sew);
    src  = to_sequential(fu_w, sew);
    vd_s = to_sequential(vd_w, 0);
    m_s  = to_sequential(m_w, 0);
    case (insn.op)
      VMAND:   res = src & m_s;
      VMOR:    res = src | m_s;
      VMXOR:   res = src ^ m_s;
      default: begin
        // LSB of each element lands at vrf_pnt + e and the tail keeps vd
        res   = vd_s;
        nelem = (DataWidth / 8) >> sew;
        for (int unsigned e = 0; e < nelem; e++) begin
          dst = insn.vrf_pnt + e;
          if (dst < DataWidth && (insn.vm || m_s[dst])) res[dst] = src[8 * (e << sew)];
        end
      end
    endcase
    return to_lanes(res);
  endfunction

  function automatic masku_insn_t make_insn(input mask_op_e op, input masku_fu_e fu,
      input sew_e sew, input logic vm, input logic [PntWidth-1:0] pnt);
    masku_insn_t insn;
    insn.op      = op;
    insn.fu      = fu;
    insn.sew     = sew;
    insn.vm      = vm;
    insn.vrf_pnt = pnt;
    return insn;
  endfunction

  // ---------------------------------------------------------------------------
  // Stimulus, one call per falling edge
  // ---------------------------------------------------------------------------
  task automatic drive_cycle();
    logic [DataWidth-1:0] garbage;
    logic [ELEN-1:0]      fu_word;
    for (int s = 0; s < 3; s++) begin
      if (fire[s]) begin
        idx[s]++;
        lane_vld[s] = '0;
      end
      for (int l = 0; l < NrLanes; l++) begin
        if (idx[s] < n_beats && !lane_vld[s][l]) begin
          lane_vld[s][l] = !random_mode || (lcg_next() >= 16'h8000);
        end
      end
    end
    // Unselected FU slot carries valid garbage
    garbage = rand_word();
    for (int l = 0; l < NrLanes; l++) begin
      fu_word = '0;
      if (idx[0] < n_beats) lane_operands_i[l].m = beat_m[idx[0]][ELEN*l +: ELEN];
      if (idx[1] < n_beats) lane_operands_i[l].vd = beat_vd[idx[1]][ELEN*l +: ELEN];
      if (idx[2] < n_beats) fu_word = beat_fu[idx[2]][ELEN*l +: ELEN];
      lane_operands_i[l].alu = (insn_i.fu == ALU) ? fu_word : garbage[ELEN*l +: ELEN];
      lane_operands_i[l].fpu = (insn_i.fu == FPU) ? fu_word : garbage[ELEN*l +: ELEN];
      lane_valid_i[l][0] = lane_vld[0][l];
      lane_valid_i[l][1] = lane_vld[1][l];
      lane_valid_i[l][2] = (insn_i.fu == ALU) ? lane_vld[2][l] : 1'b1;
      lane_valid_i[l][3] = (insn_i.fu == FPU) ? lane_vld[2][l] : 1'b1;
    end
    result_ready_i = !random_mode || (lcg_next() >= 16'h8000);
  endtask

  task automatic run_test(input string name, input masku_insn_t insn,
                          input int unsigned beats, input logic rnd);
    int unsigned err_start;
    cur_test    = name;
    insn_i      = insn;
    random_mode = rnd;
    n_beats     = beats;
    beat_m.delete();
    beat_vd.delete();
    beat_fu.delete();
    for (int unsigned i = 0; i < beats; i++) begin
      beat_m.push_back(rand_word());
      beat_vd.push_back(rand_word());
      beat_fu.push_back(rand_word());
    end
    for (int s = 0; s < 3; s++) begin
      idx[s]      = 0;
      lane_vld[s] = '0;
    end
    rcv_count = 0;
    err_start = err_count;
    while (rcv_count < beats) begin
      @(negedge clk_i);
      drive_cycle();
    end
    $display("test %-16s %0d beats, %0d errors", name, beats, err_count - err_start);
  endtask

  // ---------------------------------------------------------------------------
  // Clock, watchdog and monitors
  // ---------------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogCycles * 10);
    $display("Timeout: run did not finish within %0d cycles, test %s had %0d of %0d results",
             WatchdogCycles, cur_test, rcv_count, n_beats);
    $display(">>> FAIL");
    $finish;
  end

  // Sampled late in the cycle once inputs and combinational outputs settle
  initial begin : lane_monitor
    logic [DataWidth-1:0] bus_m, bus_vd, bus_fu;
    int unsigned          fu_slot;
    forever begin
      @(negedge clk_i);
      #4;
      fu_slot = 2 + int'(insn_i.fu);
      for (int s = 0; s < 3; s++) fire[s] = !reset_i;
      for (int l = 0; l < NrLanes; l++) begin
        bus_m[ELEN*l +: ELEN]  = lane_operands_i[l].m;
        bus_vd[ELEN*l +: ELEN] = lane_operands_i[l].vd;
        bus_fu[ELEN*l +: ELEN] = (insn_i.fu == FPU) ? lane_operands_i[l].fpu
                                                     : lane_operands_i[l].alu;
        fire[0] = fire[0] & lane_ready_o[l][0] & lane_valid_i[l][0];
        fire[1] = fire[1] & lane_ready_o[l][1] & lane_valid_i[l][1];
        fire[2] = fire[2] & lane_ready_o[l][fu_slot] & lane_valid_i[l][fu_slot];
        assert (reset_i || !lane_ready_o[l][5-fu_slot]) else begin
          $display("%s: lane %0d acknowledged the unselected FU slot", cur_test, l);
          err_count++;
        end
      end
      if (fire[2]) begin
        assert (got_m.size() > 0 && got_vd.size() > 0) else begin
          $display("%s: FU word taken before its vd and v0 words arrived", cur_test);
          err_count++;
        end
        if (got_m.size() > 0 && got_vd.size() > 0) begin
          exp_q.push_back(expected_result(insn_i, bus_fu, got_vd.pop_front(), got_m.pop_front()));
        end
      end
      if (fire[0]) got_m.push_back(bus_m);
      if (fire[1]) got_vd.push_back(bus_vd);
    end
  end

  initial begin : result_compare
    logic [DataWidth-1:0] want;
    forever begin
      @(negedge clk_i);
      #4;
      if (!reset_i && result_valid_o && result_ready_i) begin
        assert (exp_q.size() > 0) else begin
          $display("%s: result handed out with no beat outstanding", cur_test);
          err_count++;
        end
        if (exp_q.size() > 0) begin
          want = exp_q.pop_front();
          check_count++;
          assert (result_o === want) else begin
            $display("[FAIL] %s: expected %h, actual %h", cur_test, want, result_o);
            err_count++;
          end
        end
        rcv_count++;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin
    logic [15:0] r;
    lcg_state       = 32'd57628;
    reset_i         = 1'b1;
    insn_i          = '0;
    lane_operands_i = '0;
    lane_valid_i    = '0;
    result_ready_i  = 1'b0;
    random_mode     = 1'b0;
    n_beats         = 0;
    rcv_count       = 0;
    check_count     = 0;
    err_count       = 0;
    cur_test        = "reset";
    for (int s = 0; s < 3; s++) begin
      idx[s]      = 0;
      lane_vld[s] = '0;
      fire[s]     = 1'b0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    run_test("mcmp_alu_e8", make_insn(MCMP, ALU, E8, 1'b1, 7'd0), ShortBeats, 1'b0);
    run_test("mcmp_fpu_e32", make_insn(MCMP, FPU, E32, 1'b1, 7'd37), ShortBeats, 1'b0);
    run_test("mcmp_masked_e16", make_insn(MCMP, ALU, E16, 1'b0, 7'd5), ShortBeats, 1'b0);
    run_test("vmand", make_insn(VMAND, ALU, E8, 1'b1, 7'd0), ShortBeats, 1'b0);
    run_test("vmor", make_insn(VMOR, FPU, E8, 1'b1, 7'd0), ShortBeats, 1'b0);
    run_test("vmxor", make_insn(VMXOR, ALU, E8, 1'b1, 7'd0), ShortBeats, 1'b0);
    r = lcg_next();
    run_test("random_stall", make_insn(mask_op_e'(r[1:0]), masku_fu_e'(r[2]), sew_e'(r[4:3]),
             r[5], r[12:6]), TotalBeats - 6 * ShortBeats, 1'b1);

    $display("checks %0d of %0d, errors %0d, assertion failures %0d",
             check_count, TotalBeats, err_count, DUT.i_asserts.assert_fails);
    if (err_count == 0 && check_count == TotalBeats && exp_q.size() == 0 &&
        DUT.i_asserts.assert_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/masku_pkg.sv
verilog/operand_spill.sv
verilog/masku_operands.sv
verilog/masku_alu.sv
verilog/masku_top.sv
dv/masku_asserts.sv
dv/tb_masku.sv

/* run.sh */
#!/bin/sh
# Build the mask unit testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_masku -o sim_masku
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past the first assertion error so the testbench can report
./obj_dir/sim_masku +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
exit 0
